//--- src/stbuf_pkg.sv
// shared widths, vector types and store size codes, referenced by scoped name from RTL and testbench
package stbuf_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int SB_ADDR_BITS     = 16;                    // byte address into the data memory
   localparam int BYTE_WIDTH       = 4;                     // bytes per data word
   localparam int DATA_WIDTH       = 8 * BYTE_WIDTH;
   localparam int BYTE_OFFSET_BITS = $clog2(BYTE_WIDTH);   // byte position within a word
   localparam int WORD_ADDR_BITS   = SB_ADDR_BITS - BYTE_OFFSET_BITS;

   // ------------------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------------------
   typedef logic [SB_ADDR_BITS-1:0]   sb_addr_t;
   typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;         // byte address minus the offset bits
   typedef logic [BYTE_WIDTH-1:0]     byte_en_t;
   typedef logic [DATA_WIDTH-1:0]     data_t;

   // core store size, value sits in the low bytes of the store data
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } st_size_e;

endpackage

//--- src/stbuf_store_align.sv
// store input stage: takes one core store per four-phase req/ack and hands it on word-aligned
`timescale 1ns/1ps

module stbuf_store_align (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  store_req,
   input  stbuf_pkg::sb_addr_t   store_addr,
   input  stbuf_pkg::st_size_e   store_size,
   input  stbuf_pkg::data_t      store_data,
   output logic                  store_ack,
   output logic                  st_valid,
   output stbuf_pkg::word_addr_t st_waddr,
   output stbuf_pkg::byte_en_t   st_byteen,
   output stbuf_pkg::data_t      st_wdata,
   input  logic                  st_accept
);

   typedef enum logic [1:0] {
      IDLE,
      HOLD,
      ACK
   } state_e;

   state_e                                  state;
   stbuf_pkg::sb_addr_t                     req_addr;     // raw store as sampled on req
   stbuf_pkg::st_size_e                     req_size;
   stbuf_pkg::data_t                        req_data;
   logic [stbuf_pkg::BYTE_OFFSET_BITS-1:0] req_offset;
   stbuf_pkg::byte_en_t                     size_mask;
   stbuf_pkg::byte_en_t                     align_byteen;
   stbuf_pkg::data_t                        align_data;

   // ------------------------------------------------------------------------
   // byte enables and byte placement
   // ------------------------------------------------------------------------
   assign req_offset = req_addr[stbuf_pkg::BYTE_OFFSET_BITS-1:0];

   always_comb begin
      case (req_size)
         stbuf_pkg::SIZE_BYTE: size_mask = 4'b0001;
         stbuf_pkg::SIZE_HALF: size_mask = 4'b0011;
         default:              size_mask = 4'b1111;
      endcase
   end

   // bytes pushed past the top of the word are dropped
   assign align_byteen = size_mask << req_offset;
   assign align_data   = req_data << {req_offset, 3'b000};

   assign store_ack = (state == ACK);

   // ------------------------------------------------------------------------
   // handshake FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         st_valid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (store_req) begin
                  state <= HOLD;
               end
            end
            HOLD: begin
               if (!st_valid) begin
                  st_valid <= 1'b1;           // aligned copy ready next cycle
               end else if (st_accept) begin
                  st_valid <= 1'b0;
                  state    <= ACK;
               end
            end
            ACK: begin
               if (!store_req) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && store_req) begin
         req_addr <= store_addr;
         req_size <= store_size;
         req_data <= store_data;
      end
      if (state == HOLD && !st_valid) begin
         st_waddr  <= req_addr[stbuf_pkg::SB_ADDR_BITS-1:stbuf_pkg::BYTE_OFFSET_BITS];
         st_byteen <= align_byteen;
         st_wdata  <= align_data;
      end
   end

endmodule

//--- src/stbuf_entries.sv
// circular entry array: merges stores to a held word, allocates new words and presents the head
`timescale 1ns/1ps

module stbuf_entries #(
   parameter int DEPTH = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              st_valid,
   input  stbuf_pkg::word_addr_t             st_waddr,
   input  stbuf_pkg::byte_en_t               st_byteen,
   input  stbuf_pkg::data_t                  st_wdata,
   output logic                              st_accept,
   input  logic                              pop,
   output logic                              head_vld,
   output stbuf_pkg::word_addr_t             head_waddr,
   output stbuf_pkg::byte_en_t               head_byteen,
   output stbuf_pkg::data_t                  head_data,
   output logic [DEPTH-1:0]                  ent_vld,
   output stbuf_pkg::word_addr_t [DEPTH-1:0] ent_waddr,
   output stbuf_pkg::byte_en_t [DEPTH-1:0]   ent_byteen,
   output stbuf_pkg::data_t [DEPTH-1:0]      ent_data,
   output logic                              stbuf_full
);

   localparam int PTR_W = $clog2(DEPTH);

   typedef logic [PTR_W-1:0] ptr_t;

   ptr_t                                wr_ptr;
   ptr_t                                rd_ptr;
   logic [DEPTH-1:0]                    merge_vec;    // entry already holds the store's word
   logic [DEPTH-1:0]                    wr_en;
   logic                                merge_hit;
   logic                                alloc;
   stbuf_pkg::byte_en_t [DEPTH-1:0]     byteen_in;
   stbuf_pkg::data_t [DEPTH-1:0]        data_in;

   // wraps at DEPTH so non power of two depths work
   function automatic ptr_t ptr_next(input ptr_t ptr);
      return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ------------------------------------------------------------------------
   // coalescing match and allocation
   // ------------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         // the head being popped this cycle cannot take a merge
         merge_vec[i] = st_valid & ent_vld[i] & (ent_waddr[i] == st_waddr) &
                        ~(pop & (rd_ptr == ptr_t'(i)));
      end
   end

   assign merge_hit = |merge_vec;
   assign st_accept = st_valid & (merge_hit | ~stbuf_full);   // merges go in even when full
   assign alloc     = st_accept & ~merge_hit;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         wr_en[i]     = merge_vec[i] | (alloc & (wr_ptr == ptr_t'(i)));
         byteen_in[i] = st_byteen | (merge_vec[i] ? ent_byteen[i] : '0);
         for (int b = 0; b < stbuf_pkg::BYTE_WIDTH; b++) begin
            // keep an old byte only if it was enabled and the new store skips it
            data_in[i][8*b +: 8] = (merge_vec[i] & ent_byteen[i][b] & ~st_byteen[b]) ?
                                   ent_data[i][8*b +: 8] : st_wdata[8*b +: 8];
         end
      end
   end

   // ------------------------------------------------------------------------
   // valid bits and pointers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         ent_vld <= '0;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
      end else begin
         if (pop) begin
            ent_vld[rd_ptr] <= 1'b0;
            rd_ptr          <= ptr_next(rd_ptr);
         end
         if (alloc) begin
            ent_vld[wr_ptr] <= 1'b1;
            wr_ptr          <= ptr_next(wr_ptr);
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en[i]) begin
            ent_waddr[i]  <= st_waddr;
            ent_byteen[i] <= byteen_in[i];
            ent_data[i]   <= data_in[i];
         end
      end
   end

   // oldest entry goes to the drain stage
   assign head_vld    = ent_vld[rd_ptr];
   assign head_waddr  = ent_waddr[rd_ptr];
   assign head_byteen = ent_byteen[rd_ptr];
   assign head_data   = ent_data[rd_ptr];

   assign stbuf_full  = &ent_vld;

endmodule

//--- src/stbuf_load_fwd.sv
// load lookup: matches a load word against buffered stores and registers the forwarded bytes
`timescale 1ns/1ps

module stbuf_load_fwd #(
   parameter int DEPTH = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              load_en,
   input  stbuf_pkg::sb_addr_t               load_addr,
   input  logic [DEPTH-1:0]                  ent_vld,
   input  stbuf_pkg::word_addr_t [DEPTH-1:0] ent_waddr,
   input  stbuf_pkg::byte_en_t [DEPTH-1:0]   ent_byteen,
   input  stbuf_pkg::data_t [DEPTH-1:0]      ent_data,
   output stbuf_pkg::byte_en_t               fwd_byteen,
   output stbuf_pkg::data_t                  fwd_data
);

   stbuf_pkg::word_addr_t load_waddr;
   logic [DEPTH-1:0]      ld_match;
   stbuf_pkg::byte_en_t   fwd_byteen_nxt;
   stbuf_pkg::data_t      fwd_data_nxt;

   assign load_waddr = load_addr[stbuf_pkg::SB_ADDR_BITS-1:stbuf_pkg::BYTE_OFFSET_BITS];

   // stores coalesce per word, so the OR picks a single entry at most
   always_comb begin
      fwd_byteen_nxt = '0;
      fwd_data_nxt   = '0;
      for (int i = 0; i < DEPTH; i++) begin
         ld_match[i]     = load_en & ent_vld[i] & (ent_waddr[i] == load_waddr);
         fwd_byteen_nxt |= {stbuf_pkg::BYTE_WIDTH{ld_match[i]}} & ent_byteen[i];
         for (int b = 0; b < stbuf_pkg::BYTE_WIDTH; b++) begin
            fwd_data_nxt[8*b +: 8] |= {8{ld_match[i] & ent_byteen[i][b]}} &
                                      ent_data[i][8*b +: 8];    // only enabled bytes
         end
      end
   end

   // ------------------------------------------------------------------------
   // forward registers, one cycle after the lookup
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_byteen <= '0;
         fwd_data   <= '0;
      end else begin
         fwd_byteen <= fwd_byteen_nxt;
         fwd_data   <= fwd_data_nxt;
      end
   end

endmodule

//--- src/stbuf_drain.sv
// drain stage: pops the head entry and writes it to the data memory over a four-phase handshake
`timescale 1ns/1ps

module stbuf_drain (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  head_vld,
   input  stbuf_pkg::word_addr_t head_waddr,
   input  stbuf_pkg::byte_en_t   head_byteen,
   input  stbuf_pkg::data_t      head_data,
   output logic                  pop,
   output logic                  drain_req,
   output stbuf_pkg::word_addr_t drain_addr,
   output stbuf_pkg::byte_en_t   drain_byteen,
   output stbuf_pkg::data_t      drain_data,
   input  logic                  drain_ack,
   output logic                  stbuf_empty
);

   typedef enum logic [1:0] {
      DR_IDLE,
      DR_REQ,
      DR_RELEASE
   } drain_state_e;

   drain_state_e state;

   assign pop         = head_vld & (state == DR_IDLE);   // copy and pop on the same edge
   assign drain_req   = (state == DR_REQ);
   assign stbuf_empty = ~head_vld & (state == DR_IDLE);

   // ------------------------------------------------------------------------
   // handshake FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= DR_IDLE;
      end else begin
         case (state)
            DR_IDLE: begin
               if (pop) begin
                  state <= DR_REQ;
               end
            end
            DR_REQ: begin
               if (drain_ack) begin
                  state <= DR_RELEASE;
               end
            end
            DR_RELEASE: begin
               if (!drain_ack) begin
                  state <= DR_IDLE;   // memory released ack
               end
            end
            default: state <= DR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         drain_addr   <= head_waddr;
         drain_byteen <= head_byteen;
         drain_data   <= head_data;
      end
   end

endmodule

//--- src/stbuf_top.sv
// store buffer top: align, entry array, load lookup and drain stages wired together
`timescale 1ns/1ps

module stbuf_top #(
   parameter int DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   // core store port
   input  logic                  store_req,
   input  stbuf_pkg::sb_addr_t   store_addr,
   input  stbuf_pkg::st_size_e   store_size,
   input  stbuf_pkg::data_t      store_data,
   output logic                  store_ack,
   // memory drain port
   output logic                  drain_req,
   output stbuf_pkg::word_addr_t drain_addr,
   output stbuf_pkg::byte_en_t   drain_byteen,
   output stbuf_pkg::data_t      drain_data,
   input  logic                  drain_ack,
   // load lookup
   input  logic                  load_en,
   input  stbuf_pkg::sb_addr_t   load_addr,
   output stbuf_pkg::byte_en_t   fwd_byteen,
   output stbuf_pkg::data_t      fwd_data,
   // status
   output logic                  stbuf_full,
   output logic                  stbuf_empty
);

   // align to entries
   logic                              st_valid;
   stbuf_pkg::word_addr_t             st_waddr;
   stbuf_pkg::byte_en_t               st_byteen;
   stbuf_pkg::data_t                  st_wdata;
   logic                              st_accept;

   // entries to drain
   logic                              head_vld;
   stbuf_pkg::word_addr_t             head_waddr;
   stbuf_pkg::byte_en_t               head_byteen;
   stbuf_pkg::data_t                  head_data;
   logic                              pop;

   // entries to load lookup
   logic [DEPTH-1:0]                  ent_vld;
   stbuf_pkg::word_addr_t [DEPTH-1:0] ent_waddr;
   stbuf_pkg::byte_en_t [DEPTH-1:0]   ent_byteen;
   stbuf_pkg::data_t [DEPTH-1:0]      ent_data;

   stbuf_store_align u_align (
      .clk        (clk),
      .reset      (reset),
      .store_req  (store_req),
      .store_addr (store_addr),
      .store_size (store_size),
      .store_data (store_data),
      .store_ack  (store_ack),
      .st_valid   (st_valid),
      .st_waddr   (st_waddr),
      .st_byteen  (st_byteen),
      .st_wdata   (st_wdata),
      .st_accept  (st_accept)
   );

   stbuf_entries #(
      .DEPTH (DEPTH)
   ) u_entries (
      .clk         (clk),
      .reset       (reset),
      .st_valid    (st_valid),
      .st_waddr    (st_waddr),
      .st_byteen   (st_byteen),
      .st_wdata    (st_wdata),
      .st_accept   (st_accept),
      .pop         (pop),
      .head_vld    (head_vld),
      .head_waddr  (head_waddr),
      .head_byteen (head_byteen),
      .head_data   (head_data),
      .ent_vld     (ent_vld),
      .ent_waddr   (ent_waddr),
      .ent_byteen  (ent_byteen),
      .ent_data    (ent_data),
      .stbuf_full  (stbuf_full)
   );

   stbuf_load_fwd #(
      .DEPTH (DEPTH)
   ) u_load_fwd (
      .clk        (clk),
      .reset      (reset),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .ent_vld    (ent_vld),
      .ent_waddr  (ent_waddr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data)
   );

   stbuf_drain u_drain (
      .clk          (clk),
      .reset        (reset),
      .head_vld     (head_vld),
      .head_waddr   (head_waddr),
      .head_byteen  (head_byteen),
      .head_data    (head_data),
      .pop          (pop),
      .drain_req    (drain_req),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .drain_ack    (drain_ack),
      .stbuf_empty  (stbuf_empty)
   );

endmodule

//--- tests/stbuf_tb.sv
// directed testbench that drives stores, loads and the drain port of the store buffer and checks the results
`timescale 1ns/1ps

module stbuf_tb;

   localparam int DEPTH   = 4;     // matches the DUT default
   localparam int TIMEOUT = 50;    // cycles allowed for any handshake wait

   logic                  clk;
   logic                  reset;
   logic                  store_req;
   stbuf_pkg::sb_addr_t   store_addr;
   stbuf_pkg::st_size_e   store_size;
   stbuf_pkg::data_t      store_data;
   logic                  store_ack;
   logic                  drain_req;
   stbuf_pkg::word_addr_t drain_addr;
   stbuf_pkg::byte_en_t   drain_byteen;
   stbuf_pkg::data_t      drain_data;
   logic                  drain_ack;
   logic                  load_en;
   stbuf_pkg::sb_addr_t   load_addr;
   stbuf_pkg::byte_en_t   fwd_byteen;
   stbuf_pkg::data_t      fwd_data;
   logic                  stbuf_full;
   logic                  stbuf_empty;

   stbuf_top u_dut (
      .clk          (clk),
      .reset        (reset),
      .store_req    (store_req),
      .store_addr   (store_addr),
      .store_size   (store_size),
      .store_data   (store_data),
      .store_ack    (store_ack),
      .drain_req    (drain_req),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .drain_ack    (drain_ack),
      .load_en      (load_en),
      .load_addr    (load_addr),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data),
      .stbuf_full   (stbuf_full),
      .stbuf_empty  (stbuf_empty)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // expected values from the align rule
   // ------------------------------------------------------------------------
   function automatic stbuf_pkg::byte_en_t align_be(input stbuf_pkg::st_size_e size,
                                                    input logic [1:0] off);
      logic [3:0] mask;
      mask = (size == stbuf_pkg::SIZE_BYTE) ? 4'h1 :
             (size == stbuf_pkg::SIZE_HALF) ? 4'h3 : 4'hf;
      return mask << off;      // bytes past byte 3 fall off
   endfunction

   function automatic stbuf_pkg::data_t align_data(input stbuf_pkg::data_t data,
                                                   input logic [1:0] off);
      return data << (8 * off);
   endfunction

   // keeps only the bytes the store size covers
   function automatic stbuf_pkg::data_t size_value(input stbuf_pkg::st_size_e size,
                                                   input stbuf_pkg::data_t data);
      if (size == stbuf_pkg::SIZE_BYTE) return data & 32'h0000_00ff;
      if (size == stbuf_pkg::SIZE_HALF) return data & 32'h0000_ffff;
      return data;
   endfunction

   function automatic stbuf_pkg::word_addr_t word_of(input stbuf_pkg::sb_addr_t addr);
      return addr[15:2];
   endfunction

   // ------------------------------------------------------------------------
   // error reporting and checks
   // ------------------------------------------------------------------------
   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic timeout_stop(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      stop_run();
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
         stop_run();
      end
   endtask

   // ------------------------------------------------------------------------
   // drive tasks
   // ------------------------------------------------------------------------
   task automatic start_store(input stbuf_pkg::sb_addr_t addr,
                              input stbuf_pkg::st_size_e size, input stbuf_pkg::data_t data);
      @(negedge clk);
      store_req  = 1'b1;
      store_addr = addr;
      store_size = size;
      store_data = data;
   endtask

   task automatic finish_store();
      int n;
      n = 0;
      while (store_ack !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) timeout_stop("store_ack to rise");
      end
      store_req = 1'b0;
      n = 0;
      while (store_ack !== 1'b0) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) timeout_stop("store_ack to fall");
      end
   endtask

   task automatic do_store(input stbuf_pkg::sb_addr_t addr,
                           input stbuf_pkg::st_size_e size, input stbuf_pkg::data_t data);
      start_store(addr, size, data);
      finish_store();
   endtask

   // with hold set, the request is checked but left without ack
   task automatic expect_drain(input stbuf_pkg::word_addr_t exp_addr,
                               input stbuf_pkg::byte_en_t exp_be,
                               input stbuf_pkg::data_t exp_data, input bit hold);
      int n;
      n = 0;
      while (drain_req !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) timeout_stop("drain_req to rise");
      end
      check("drain_addr", 32'(drain_addr), 32'(exp_addr));
      check("drain_byteen", 32'(drain_byteen), 32'(exp_be));
      check("drain_data", drain_data, exp_data);
      if (!hold) begin
         drain_ack = 1'b1;
         n = 0;
         while (drain_req !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_stop("drain_req to fall");
         end
         drain_ack = 1'b0;
      end
   endtask

   task automatic do_load(input stbuf_pkg::sb_addr_t addr, input stbuf_pkg::byte_en_t exp_be,
                          input stbuf_pkg::data_t exp_data);
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = addr;
      @(negedge clk);                                  // one edge later
      check("fwd_byteen", 32'(fwd_byteen), 32'(exp_be));
      check("fwd_data", fwd_data, exp_data);
      load_en = 1'b0;
      @(negedge clk);                                  // same address, load_en low
      check("fwd_byteen", 32'(fwd_byteen), 32'd0);
      check("fwd_data", fwd_data, 32'd0);
   endtask

   task automatic wait_empty();
      int n;
      n = 0;
      while (stbuf_empty !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) timeout_stop("stbuf_empty to return");
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset_state();
      @(negedge clk);
      check("stbuf_empty", 32'(stbuf_empty), 32'd1);
      check("stbuf_full", 32'(stbuf_full), 32'd0);
      check("store_ack", 32'(store_ack), 32'd0);
      check("drain_req", 32'(drain_req), 32'd0);
      check("fwd_byteen", 32'(fwd_byteen), 32'd0);
      check("fwd_data", fwd_data, 32'd0);
   endtask

   task automatic test_store_sizes();
      stbuf_pkg::sb_addr_t addr [3];
      stbuf_pkg::st_size_e size [3];
      stbuf_pkg::data_t    data [3];
      addr[0] = 16'h0101;                             // byte at offset 1
      addr[1] = 16'h0206;                             // half at offset 2
      addr[2] = 16'h0308;
      size[0] = stbuf_pkg::SIZE_BYTE;
      size[1] = stbuf_pkg::SIZE_HALF;
      size[2] = stbuf_pkg::SIZE_WORD;
      for (int i = 0; i < 3; i++) begin
         data[i] = size_value(size[i], $urandom);
         do_store(addr[i], size[i], data[i]);
      end
      check("stbuf_empty", 32'(stbuf_empty), 32'd0);
      for (int i = 0; i < 3; i++) begin
         expect_drain(word_of(addr[i]), align_be(size[i], addr[i][1:0]),
                      align_data(data[i], addr[i][1:0]), 1'b0);
      end
      wait_empty();
   endtask

   task automatic test_merge_forward();
      stbuf_pkg::data_t    x_data;
      stbuf_pkg::data_t    b_data;
      stbuf_pkg::data_t    h_data;
      stbuf_pkg::data_t    z_data;
      stbuf_pkg::byte_en_t y_be;
      stbuf_pkg::data_t    y_data;
      x_data = $urandom;
      b_data = size_value(stbuf_pkg::SIZE_BYTE, $urandom);
      h_data = size_value(stbuf_pkg::SIZE_HALF, $urandom);
      z_data = $urandom;                              // upper bytes left random
      do_store(16'h0500, stbuf_pkg::SIZE_WORD, x_data);
      expect_drain(word_of(16'h0500), 4'hf, x_data, 1'b1);   // X parked in drain
      do_store(16'h0600, stbuf_pkg::SIZE_BYTE, b_data);
      do_store(16'h0602, stbuf_pkg::SIZE_HALF, h_data);
      do_store(16'h0801, stbuf_pkg::SIZE_BYTE, z_data);
      y_be   = align_be(stbuf_pkg::SIZE_BYTE, 2'd0) | align_be(stbuf_pkg::SIZE_HALF, 2'd2);
      y_data = align_data(b_data, 2'd0) | align_data(h_data, 2'd2);
      do_load(16'h0601, y_be, y_data);
      // only the enabled byte of the shifted data comes back
      do_load(16'h0801, align_be(stbuf_pkg::SIZE_BYTE, 2'd1),
              align_data(size_value(stbuf_pkg::SIZE_BYTE, z_data), 2'd1));
      do_load(16'h0500, 4'h0, 32'd0);                 // already popped
      do_load(16'h0700, 4'h0, 32'd0);                 // never stored
      expect_drain(word_of(16'h0500), 4'hf, x_data, 1'b0);
      expect_drain(word_of(16'h0600), y_be, y_data, 1'b0);
      expect_drain(word_of(16'h0801), align_be(stbuf_pkg::SIZE_BYTE, 2'd1),
                   align_data(z_data, 2'd1), 1'b0);
      wait_empty();
   endtask

   task automatic test_backpressure();
      stbuf_pkg::data_t vals [DEPTH+2];
      for (int i = 0; i < DEPTH + 2; i++) vals[i] = $urandom;
      do_store(16'h0400, stbuf_pkg::SIZE_WORD, vals[0]);
      expect_drain(word_of(16'h0400), 4'hf, vals[0], 1'b1);
      for (int i = 1; i <= DEPTH; i++) begin
         do_store(stbuf_pkg::sb_addr_t'(16'h0400 + 4 * i), stbuf_pkg::SIZE_WORD, vals[i]);
      end
      check("stbuf_full", 32'(stbuf_full), 32'd1);
      start_store(stbuf_pkg::sb_addr_t'(16'h0400 + 4 * (DEPTH + 1)), stbuf_pkg::SIZE_WORD,
                  vals[DEPTH+1]);
      repeat (20) begin
         @(negedge clk);
         check("store_ack", 32'(store_ack), 32'd0);
      end
      expect_drain(word_of(16'h0400), 4'hf, vals[0], 1'b0);
      finish_store();                                 // freed slot takes the waiting store
      for (int i = 1; i <= DEPTH + 1; i++) begin
         expect_drain(word_of(stbuf_pkg::sb_addr_t'(16'h0400 + 4 * i)), 4'hf, vals[i], 1'b0);
      end
      wait_empty();
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      reset      = 1'b1;
      store_req  = 1'b0;
      store_addr = '0;
      store_size = stbuf_pkg::SIZE_BYTE;
      store_data = '0;
      drain_ack  = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      void'($urandom(69));
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      test_reset_state();
      test_store_sizes();
      test_merge_forward();
      test_backpressure();
      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- compile.f
src/stbuf_pkg.sv
src/stbuf_store_align.sv
src/stbuf_entries.sv
src/stbuf_load_fwd.sv
src/stbuf_drain.sv
src/stbuf_top.sv
tests/stbuf_tb.sv

//--- run.sh
#!/bin/sh
# build the store buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   --top-module stbuf_tb -f compile.f -o stbuf_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed"
   exit $status
fi

./obj_dir/stbuf_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
   exit $status
fi

echo "simulation finished"
exit 0
